// File: hw/lc3b_commit_pkg.sv
package lc3b_commit_pkg;

	////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////
	localparam int word_width = 16;
	localparam int reg_count = 8;
	localparam int reg_sel_width = 3;
	localparam int rob_depth = 8;
	localparam int rob_tag_width = 3;
	localparam int nzp_width = 3;
	localparam int trap_vector_reg = 7;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		st_idle = 2'b00,
		st_bus  = 2'b01,
		st_done = 2'b10
	} store_state;

	// Branches and stores leave the register file alone
	function automatic logic writes_reg(input lc3b_opcode op);
		case (op)
			op_br, op_str, op_stb: writes_reg = 1'b0;
			default: writes_reg = 1'b1;
		endcase
	endfunction

	function automatic logic [reg_sel_width-1:0] target_reg(input lc3b_opcode op,
			input logic [reg_sel_width-1:0] dest);
		if (op == op_trap)
			target_reg = reg_sel_width'(trap_vector_reg); // Trap vector always lands in R7
		else
			target_reg = dest;
	endfunction

endpackage

// File: hw/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic disp_valid,
	input  lc3b_commit_pkg::lc3b_opcode disp_opcode,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] disp_dest,
	input  logic disp_predict,
	output logic disp_ready,
	output logic [lc3b_commit_pkg::rob_tag_width-1:0] disp_tag,
	input  logic cmpl_valid,
	input  logic [lc3b_commit_pkg::rob_tag_width-1:0] cmpl_tag,
	input  logic [lc3b_commit_pkg::word_width-1:0] cmpl_value,
	input  logic [lc3b_commit_pkg::word_width-1:0] cmpl_addr,
	input  logic retire,
	input  logic flush,
	output logic head_valid,
	output lc3b_commit_pkg::lc3b_opcode head_opcode,
	output logic [lc3b_commit_pkg::reg_sel_width-1:0] head_dest,
	output logic head_predict,
	output logic [lc3b_commit_pkg::word_width-1:0] head_value,
	output logic [lc3b_commit_pkg::word_width-1:0] head_addr,
	output logic [lc3b_commit_pkg::rob_tag_width-1:0] head_tag
);

	lc3b_commit_pkg::lc3b_opcode opcode_q [lc3b_commit_pkg::rob_depth];
	logic [lc3b_commit_pkg::reg_sel_width-1:0] dest_q [lc3b_commit_pkg::rob_depth];
	logic [lc3b_commit_pkg::word_width-1:0] value_q [lc3b_commit_pkg::rob_depth];
	logic [lc3b_commit_pkg::word_width-1:0] addr_q [lc3b_commit_pkg::rob_depth];
	logic [lc3b_commit_pkg::rob_depth-1:0] predict_q;
	logic [lc3b_commit_pkg::rob_depth-1:0] done_q;

	logic [lc3b_commit_pkg::rob_tag_width-1:0] head_ptr;
	logic [lc3b_commit_pkg::rob_tag_width-1:0] tail_ptr;
	logic [lc3b_commit_pkg::rob_tag_width:0] count;
	logic push;
	logic pop;

	assign disp_ready = (count != lc3b_commit_pkg::rob_depth) && !flush; // No entry slips in during a flush
	assign disp_tag = tail_ptr;
	assign push = disp_valid && disp_ready;
	assign pop = retire;

	////////////////////////////////////////
	// Pointers, count and done bits
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
			done_q <= '0;
		end else if (flush) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
			done_q <= '0;
		end else begin
			if (push)
				tail_ptr <= tail_ptr + 1'b1;
			if (pop)
				head_ptr <= head_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			if (cmpl_valid)
				done_q[cmpl_tag] <= 1'b1;
			if (push)
				done_q[tail_ptr] <= 1'b0; // A fresh entry waits for its completion
		end
	end

	////////////////////////////////////////
	// Entry payload
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (push) begin
			opcode_q[tail_ptr] <= disp_opcode;
			dest_q[tail_ptr] <= disp_dest;
			predict_q[tail_ptr] <= disp_predict;
		end
		if (cmpl_valid) begin
			value_q[cmpl_tag] <= cmpl_value;
			addr_q[cmpl_tag] <= cmpl_addr;
		end
	end

	assign head_valid = (count != '0) && done_q[head_ptr];
	assign head_opcode = opcode_q[head_ptr];
	assign head_dest = dest_q[head_ptr];
	assign head_predict = predict_q[head_ptr];
	assign head_value = value_q[head_ptr];
	assign head_addr = addr_q[head_ptr];
	assign head_tag = head_ptr;

endmodule

// File: hw/commit_control.sv
`timescale 1ns/1ns

module commit_control (
	input  logic head_valid,
	input  lc3b_commit_pkg::lc3b_opcode head_opcode,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] head_dest,
	input  logic head_predict,
	input  logic [lc3b_commit_pkg::word_width-1:0] head_value,
	input  logic [lc3b_commit_pkg::rob_tag_width-1:0] head_tag,
	input  logic [lc3b_commit_pkg::rob_tag_width-1:0] rf_busy_tag,
	input  logic taken,
	input  logic store_done,
	output logic retire,
	output logic rf_write,
	output logic [lc3b_commit_pkg::reg_sel_width-1:0] rf_dest,
	output logic [lc3b_commit_pkg::word_width-1:0] rf_value,
	output logic rf_clear_busy,
	output logic [lc3b_commit_pkg::reg_sel_width-1:0] busy_tag_sel,
	output logic cc_load,
	output logic flush,
	output logic redirect,
	output logic [lc3b_commit_pkg::word_width-1:0] new_pc,
	output logic store_req
);

	logic owner_match;

	assign rf_dest = lc3b_commit_pkg::target_reg(head_opcode, head_dest);
	assign busy_tag_sel = rf_dest;
	assign rf_value = head_value; // For a trap the value is the vector itself
	assign new_pc = head_value;

	// Only the youngest writer of a register may release it
	assign owner_match = (rf_busy_tag == head_tag);

	////////////////////////////////////////
	// Retire decision for the head entry
	////////////////////////////////////////
	always_comb begin
		retire = 1'b0;
		rf_write = 1'b0;
		rf_clear_busy = 1'b0;
		cc_load = 1'b0;
		flush = 1'b0;
		redirect = 1'b0;
		store_req = 1'b0;
		if (head_valid) begin
			case (head_opcode)
				lc3b_commit_pkg::op_add,
				lc3b_commit_pkg::op_and,
				lc3b_commit_pkg::op_not,
				lc3b_commit_pkg::op_shf,
				lc3b_commit_pkg::op_lea,
				lc3b_commit_pkg::op_ldr,
				lc3b_commit_pkg::op_ldb: begin
					rf_write = 1'b1;
					rf_clear_busy = owner_match;
					cc_load = 1'b1;
					retire = 1'b1;
				end
				lc3b_commit_pkg::op_jsr: begin
					rf_write = 1'b1; // Link write leaves the condition codes alone
					rf_clear_busy = owner_match;
					retire = 1'b1;
				end
				lc3b_commit_pkg::op_br: begin
					if (taken != head_predict) begin
						flush = 1'b1; // Mispredict throws away everything younger
						redirect = 1'b1;
					end
					retire = 1'b1;
				end
				lc3b_commit_pkg::op_trap: begin
					rf_write = 1'b1;
					rf_clear_busy = owner_match;
					flush = 1'b1;
					redirect = 1'b1;
					retire = 1'b1;
				end
				lc3b_commit_pkg::op_str,
				lc3b_commit_pkg::op_stb: begin
					store_req = 1'b1; // Head stalls until the bus cycle ends
					retire = store_done;
				end
				default: begin
					retire = 1'b1; // Unknown opcode is dropped so the buffer keeps moving
				end
			endcase
		end
	end

endmodule

// File: hw/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve (
	input  logic clk,
	input  logic rst_n,
	input  logic cc_load,
	input  logic [lc3b_commit_pkg::word_width-1:0] result,
	input  logic [lc3b_commit_pkg::nzp_width-1:0] cond,
	output logic taken
);

	logic [lc3b_commit_pkg::nzp_width-1:0] gen_cc;
	logic [lc3b_commit_pkg::nzp_width-1:0] cc_q;
	logic neg;
	logic zero;

	////////////////////////////////////////
	// Condition-code generation
	////////////////////////////////////////
	assign neg = result[lc3b_commit_pkg::word_width-1];
	assign zero = (result == '0);
	assign gen_cc = {neg, zero, !neg && !zero}; // Bit 2 is n, bit 0 is p

	always_ff @(posedge clk) begin
		if (!rst_n)
			cc_q <= '0;
		else if (cc_load)
			cc_q <= gen_cc;
	end

	// Any requested flag that is set makes the branch taken
	assign taken = |(cond & cc_q);

endmodule

// File: hw/arch_regfile.sv
`timescale 1ns/1ns

module arch_regfile (
	input  logic clk,
	input  logic rst_n,
	input  logic disp_mark,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] disp_dest,
	input  logic [lc3b_commit_pkg::rob_tag_width-1:0] disp_tag,
	input  logic rf_write,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] rf_dest,
	input  logic [lc3b_commit_pkg::word_width-1:0] rf_value,
	input  logic rf_clear_busy,
	input  logic flush,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] busy_tag_sel,
	output logic [lc3b_commit_pkg::rob_tag_width-1:0] rf_busy_tag,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] rd_sel,
	output logic [lc3b_commit_pkg::word_width-1:0] rd_value,
	output logic rd_busy,
	output logic [lc3b_commit_pkg::rob_tag_width-1:0] rd_tag
);

	logic [lc3b_commit_pkg::word_width-1:0] value_q [lc3b_commit_pkg::reg_count];
	logic [lc3b_commit_pkg::rob_tag_width-1:0] tag_q [lc3b_commit_pkg::reg_count];
	logic [lc3b_commit_pkg::reg_count-1:0] busy_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < lc3b_commit_pkg::reg_count; i++)
				value_q[i] <= '0;
		end else if (rf_write) begin
			value_q[rf_dest] <= rf_value; // Written even if a younger writer keeps it busy
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= '0;
		end else if (flush) begin
			busy_q <= '0;
		end else begin
			if (rf_clear_busy)
				busy_q[rf_dest] <= 1'b0;
			if (disp_mark)
				busy_q[disp_dest] <= 1'b1; // Later assignment wins over the clear
		end
	end

	always_ff @(posedge clk) begin
		if (disp_mark)
			tag_q[disp_dest] <= disp_tag;
	end

	assign rf_busy_tag = tag_q[busy_tag_sel];

	assign rd_value = value_q[rd_sel];
	assign rd_busy = busy_q[rd_sel];
	assign rd_tag = tag_q[rd_sel];

endmodule

// File: hw/store_commit_port.sv
`timescale 1ns/1ns

module store_commit_port (
	input  logic clk,
	input  logic rst_n,
	input  logic store_req,
	input  logic store_byte,
	input  logic [lc3b_commit_pkg::word_width-1:0] addr,
	input  logic [lc3b_commit_pkg::word_width-1:0] data,
	output logic store_done,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [lc3b_commit_pkg::word_width-1:0] wb_adr,
	output logic [lc3b_commit_pkg::word_width-1:0] wb_dat_o,
	output logic [1:0] wb_sel,
	input  logic wb_ack
);

	lc3b_commit_pkg::store_state state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= lc3b_commit_pkg::st_idle;
		end else begin
			case (state)
				lc3b_commit_pkg::st_idle: if (store_req) state <= lc3b_commit_pkg::st_bus;
				lc3b_commit_pkg::st_bus:  if (wb_ack) state <= lc3b_commit_pkg::st_done;
				default: state <= lc3b_commit_pkg::st_idle; // One quiet cycle before the next store
			endcase
		end
	end

	// Bus payload is captured as the cycle starts
	always_ff @(posedge clk) begin
		if (state == lc3b_commit_pkg::st_idle && store_req) begin
			wb_adr <= addr;
			if (store_byte) begin
				wb_dat_o <= {data[7:0], data[7:0]};
				wb_sel <= addr[0] ? 2'b10 : 2'b01;
			end else begin
				wb_dat_o <= data;
				wb_sel <= 2'b11;
			end
		end
	end

	assign wb_cyc = (state == lc3b_commit_pkg::st_bus);
	assign wb_stb = wb_cyc;
	assign wb_we = wb_cyc;
	assign store_done = wb_cyc && wb_ack;

endmodule

// File: hw/commit_unit_top.sv
`timescale 1ns/1ns

module commit_unit_top (
	input  logic clk,
	input  logic rst_n,
	input  logic disp_valid,
	input  lc3b_commit_pkg::lc3b_opcode disp_opcode,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] disp_dest,
	input  logic disp_predict,
	output logic disp_ready,
	output logic [lc3b_commit_pkg::rob_tag_width-1:0] disp_tag,
	input  logic cmpl_valid,
	input  logic [lc3b_commit_pkg::rob_tag_width-1:0] cmpl_tag,
	input  logic [lc3b_commit_pkg::word_width-1:0] cmpl_value,
	input  logic [lc3b_commit_pkg::word_width-1:0] cmpl_addr,
	output logic flush,
	output logic redirect,
	output logic [lc3b_commit_pkg::word_width-1:0] new_pc,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [lc3b_commit_pkg::word_width-1:0] wb_adr,
	output logic [lc3b_commit_pkg::word_width-1:0] wb_dat_o,
	output logic [1:0] wb_sel,
	input  logic wb_ack,
	input  logic [lc3b_commit_pkg::reg_sel_width-1:0] rd_sel,
	output logic [lc3b_commit_pkg::word_width-1:0] rd_value,
	output logic rd_busy,
	output logic [lc3b_commit_pkg::rob_tag_width-1:0] rd_tag
);

	logic head_valid;
	lc3b_commit_pkg::lc3b_opcode head_opcode;
	logic [lc3b_commit_pkg::reg_sel_width-1:0] head_dest;
	logic head_predict;
	logic [lc3b_commit_pkg::word_width-1:0] head_value;
	logic [lc3b_commit_pkg::word_width-1:0] head_addr;
	logic [lc3b_commit_pkg::rob_tag_width-1:0] head_tag;
	logic retire;
	logic rf_write;
	logic rf_clear_busy;
	logic [lc3b_commit_pkg::reg_sel_width-1:0] rf_dest;
	logic [lc3b_commit_pkg::word_width-1:0] rf_value;
	logic [lc3b_commit_pkg::reg_sel_width-1:0] busy_tag_sel;
	logic [lc3b_commit_pkg::rob_tag_width-1:0] rf_busy_tag;
	logic cc_load;
	logic taken;
	logic store_req;
	logic store_done;
	logic disp_mark;
	logic [lc3b_commit_pkg::reg_sel_width-1:0] disp_target;

	////////////////////////////////////////
	// Dispatch-side register reservation
	////////////////////////////////////////
	assign disp_mark = disp_valid && disp_ready && lc3b_commit_pkg::writes_reg(disp_opcode);
	assign disp_target = lc3b_commit_pkg::target_reg(disp_opcode, disp_dest);

	reorder_buffer u_rob (
		.clk, .rst_n, .disp_valid, .disp_opcode, .disp_dest, .disp_predict,
		.disp_ready, .disp_tag, .cmpl_valid, .cmpl_tag, .cmpl_value, .cmpl_addr,
		.retire, .flush, .head_valid, .head_opcode, .head_dest, .head_predict,
		.head_value, .head_addr, .head_tag
	);

	commit_control u_ctrl (
		.head_valid, .head_opcode, .head_dest, .head_predict, .head_value, .head_tag,
		.rf_busy_tag, .taken, .store_done, .retire, .rf_write, .rf_dest, .rf_value,
		.rf_clear_busy, .busy_tag_sel, .cc_load, .flush, .redirect, .new_pc, .store_req
	);

	branch_resolve u_br (
		.clk, .rst_n, .cc_load, .result(head_value), .cond(head_dest), .taken
	);

	arch_regfile u_rf (
		.clk, .rst_n, .disp_mark, .disp_dest(disp_target), .disp_tag, .rf_write, .rf_dest,
		.rf_value, .rf_clear_busy, .flush, .busy_tag_sel, .rf_busy_tag, .rd_sel,
		.rd_value, .rd_busy, .rd_tag
	);

	store_commit_port u_st (
		.clk, .rst_n, .store_req, .store_byte(head_opcode == lc3b_commit_pkg::op_stb),
		.addr(head_addr), .data(head_value), .store_done, .wb_cyc, .wb_stb, .wb_we,
		.wb_adr, .wb_dat_o, .wb_sel, .wb_ack
	);

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk; // 8 ns period

endmodule

// File: sim/commit_unit_tb.sv
`timescale 1ns/1ns

module commit_unit_tb;

	localparam int num_rows = 17;
	localparam int cycle_limit = num_rows * 12;

	typedef struct packed {
		logic [3:0] grp;
		logic [1:0] mode; // 0 retires in its group, 1 completes with the next one, 2 is flushed
		lc3b_commit_pkg::lc3b_opcode op;
		logic [2:0] dest;
		logic pred;
		logic [15:0] value;
		logic [15:0] addr;
		logic [15:0] exp; // Register value, or the bus word of a store
		logic exp_busy;
		logic exp_redir;
	} row_t;

	logic clk;
	logic rst_n;
	logic disp_valid, disp_predict, disp_ready, cmpl_valid;
	lc3b_commit_pkg::lc3b_opcode disp_opcode;
	logic [2:0] disp_dest, disp_tag, cmpl_tag, rd_sel, rd_tag;
	logic [15:0] cmpl_value, cmpl_addr, new_pc, wb_adr, wb_dat_o, rd_value;
	logic flush, redirect, wb_cyc, wb_stb, wb_we, wb_ack, rd_busy;
	logic [1:0] wb_sel;

	row_t rows [num_rows];
	logic [2:0] tags [num_rows];
	logic [num_rows-1:0] retired = '0;
	logic [num_rows-1:0] redir_seen = '0;
	logic [15:0] st_adr [num_rows];
	logic [15:0] st_dat [num_rows];
	logic [1:0] st_sel [num_rows];
	int row_err [num_rows];
	int ack_delay [num_rows];
	int order [$];
	int row_n = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int cycles = 0;
	int bus_count = 0;
	int stores_retired = 0;
	int ack_wait = 0;
	logic [15:0] bus_adr, bus_dat;
	logic [1:0] bus_sel;
	logic [15:0] m_regs [8];
	logic [2:0] m_tag [8];
	logic [7:0] m_busy = '0;
	logic [2:0] m_cc = '0;
	logic [2:0] m_tail = '0;

	clock_gen u_clk (.clk);

	commit_unit_top u_dut (.*);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic reg_written(input lc3b_commit_pkg::lc3b_opcode op);
		reg_written = (op != lc3b_commit_pkg::op_br) && (op != lc3b_commit_pkg::op_str) &&
			(op != lc3b_commit_pkg::op_stb);
	endfunction

	function automatic logic [2:0] target_of(input row_t r);
		target_of = (r.op == lc3b_commit_pkg::op_trap) ? 3'd7 : r.dest; // Traps land in R7
	endfunction

	function automatic logic [2:0] flags_of(input logic [15:0] v);
		flags_of = {v[15], v == 16'h0, !v[15] && v != 16'h0};
	endfunction

	task automatic add_row(input logic [3:0] grp, input logic [1:0] mode,
			input lc3b_commit_pkg::lc3b_opcode op, input logic [2:0] dest, input logic pred,
			input logic [15:0] value, input logic [15:0] addr, input logic [15:0] exp,
			input logic exp_busy, input logic exp_redir);
		rows[row_n] = {grp, mode, op, dest, pred, value, addr, exp, exp_busy, exp_redir};
		row_n++;
	endtask

	task automatic note_error(input int k);
		errors++;
		if (k >= 0)
			row_err[k]++;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic dispatch(input int k);
		logic accepted;
		disp_valid = 1'b1;
		disp_opcode = rows[k].op;
		disp_dest = rows[k].dest;
		disp_predict = rows[k].pred;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = disp_ready;
			if (accepted && disp_tag !== m_tail) begin
				$display("Error: disp_tag 0x%h, expected 0x%h", disp_tag, m_tail);
				note_error(k);
			end
			step();
		end
		disp_valid = 1'b0;
		tags[k] = m_tail; // Entries are handed out in a circle from the tail
		m_tail++;
		if (rows[k].mode != 2)
			order.push_back(k); // Expected retire order is dispatch order
		if (reg_written(rows[k].op)) begin
			m_busy[target_of(rows[k])] = 1'b1;
			m_tag[target_of(rows[k])] = tags[k];
		end
	endtask

	task automatic complete(input int k);
		cmpl_valid = 1'b1;
		cmpl_tag = tags[k];
		cmpl_value = rows[k].value;
		cmpl_addr = rows[k].addr;
		step();
		cmpl_valid = 1'b0;
	endtask

	task automatic read_reg(input logic [2:0] r, output logic [15:0] v, output logic b,
			output logic [2:0] t);
		rd_sel = r;
		@(negedge clk);
		v = rd_value;
		b = rd_busy;
		t = rd_tag;
		step();
	endtask

	////////////////////////////////////////
	// Retire monitor and reference model
	////////////////////////////////////////
	task automatic retire_entry(input int k);
		logic exp_redir;
		logic [2:0] t;
		exp_redir = (rows[k].op == lc3b_commit_pkg::op_trap) ||
			(rows[k].op == lc3b_commit_pkg::op_br && (|(rows[k].dest & m_cc)) != rows[k].pred);
		retired[k] = 1'b1;
		redir_seen[k] = redirect;
		if (rows[k].op == lc3b_commit_pkg::op_str || rows[k].op == lc3b_commit_pkg::op_stb) begin
			stores_retired++;
			st_adr[k] = bus_adr;
			st_dat[k] = bus_dat;
			st_sel[k] = bus_sel;
		end
		if (bus_count != stores_retired) begin
			$display("Error: store cycles 0x%h at row %0d, expected 0x%h", bus_count, k,
				stores_retired);
			note_error(k);
		end
		if (u_dut.rf_value !== rows[k].value) begin // Catches retirement out of dispatch order
			$display("Error: rf_value 0x%h at retire, expected 0x%h", u_dut.rf_value,
				rows[k].value);
			note_error(k);
		end
		if (redirect !== exp_redir || flush !== exp_redir || (exp_redir && new_pc !== rows[k].value))
		begin
			$display("Error: redirect 0x%h flush 0x%h new_pc 0x%h, expected 0x%h 0x%h 0x%h",
				redirect, flush, new_pc, exp_redir, exp_redir, rows[k].value);
			note_error(k);
		end
		if (reg_written(rows[k].op)) begin
			t = target_of(rows[k]);
			m_regs[t] = rows[k].value;
			if (m_tag[t] == tags[k])
				m_busy[t] = 1'b0;
			if (rows[k].op != lc3b_commit_pkg::op_jsr && rows[k].op != lc3b_commit_pkg::op_trap)
				m_cc = flags_of(rows[k].value);
		end
		if (exp_redir) begin
			m_busy = '0;
			m_tail = '0;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (wb_cyc && wb_stb && wb_ack) begin
				bus_count++;
				bus_adr = wb_adr;
				bus_dat = wb_dat_o;
				bus_sel = wb_sel;
				if (!wb_we) begin
					$display("Error: wb_we 0x0 during a store cycle, expected 0x1");
					note_error(-1);
				end
			end
			if (u_dut.retire) begin
				if (order.size() == 0) begin
					$display("The DUT retired an entry that no test expected to retire");
					note_error(-1);
				end else
					retire_entry(order.pop_front());
			end
		end
	end

	// Memory responder with a random wait of 0 to 3 cycles
	always @(posedge clk) begin
		#1;
		if (wb_ack) begin
			wb_ack = 1'b0;
			ack_wait = ack_delay[bus_count % num_rows];
		end else if (wb_cyc && wb_stb) begin
			if (ack_wait == 0)
				wb_ack = 1'b1;
			else
				ack_wait--;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Row checks
	////////////////////////////////////////
	task automatic check_row(input int k);
		logic [15:0] v;
		logic b;
		logic [2:0] t;
		logic [1:0] sel;
		lc3b_commit_pkg::lc3b_opcode op;
		op = rows[k].op;
		if ((op == lc3b_commit_pkg::op_br || op == lc3b_commit_pkg::op_trap) &&
				redir_seen[k] !== rows[k].exp_redir) begin
			$display("Error: redirect 0x%h, expected 0x%h", redir_seen[k], rows[k].exp_redir);
			note_error(k);
		end
		if (op == lc3b_commit_pkg::op_str || op == lc3b_commit_pkg::op_stb) begin
			sel = (op == lc3b_commit_pkg::op_str) ? 2'b11 : (rows[k].addr[0] ? 2'b10 : 2'b01);
			if (st_adr[k] !== rows[k].addr || st_dat[k] !== rows[k].exp || st_sel[k] !== sel) begin
				$display("Error: wb_adr 0x%h wb_dat_o 0x%h wb_sel 0x%h, expected 0x%h 0x%h 0x%h",
					st_adr[k], st_dat[k], st_sel[k], rows[k].addr, rows[k].exp, sel);
				note_error(k);
			end
		end
		if (reg_written(op)) begin
			read_reg(target_of(rows[k]), v, b, t);
			if (v !== rows[k].exp || b !== rows[k].exp_busy) begin
				$display("Error: R%0d rd_value 0x%h rd_busy 0x%h, expected 0x%h and 0x%h",
					target_of(rows[k]), v, b, rows[k].exp, rows[k].exp_busy);
				note_error(k);
			end
			if (rows[k].exp_busy && t !== m_tag[target_of(rows[k])]) begin
				$display("Error: R%0d rd_tag 0x%h, expected 0x%h", target_of(rows[k]), t,
					m_tag[target_of(rows[k])]);
				note_error(k);
			end
		end
		if (rows[k].exp_redir) begin
			if (disp_ready !== 1'b1) begin
				$display("Error: disp_ready 0x%h after the flush, expected 0x1", disp_ready);
				note_error(k);
			end
			for (int r = 0; r < 8; r++) begin
				read_reg(r, v, b, t);
				if (b !== 1'b0) begin
					$display("Error: R%0d rd_busy 0x%h after the flush, expected 0x0", r, b);
					note_error(k);
				end
			end
		end
		if (row_err[k] == 0)
			passed++;
		else
			failed++;
		$display("Test %0d %s: %s", k, op.name(), (row_err[k] == 0) ? "pass" : "FAIL");
	endtask

	initial begin
		int i, k, first, last, carry, checked;
		int unsigned seed_val;
		logic [15:0] v;
		logic b;
		logic [2:0] t;
		seed_val = $urandom(32'h606b_7d9e);
		ack_delay[0] = seed_val % 4;
		for (k = 1; k < num_rows; k++)
			ack_delay[k] = $urandom % 4;
		ack_wait = ack_delay[0];
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp_opcode = lc3b_commit_pkg::op_add;
		disp_dest = '0;
		disp_predict = 1'b0;
		cmpl_valid = 1'b0;
		cmpl_tag = '0;
		cmpl_value = '0;
		cmpl_addr = '0;
		wb_ack = 1'b0;
		rd_sel = '0;
		for (k = 0; k < 8; k++) begin
			m_regs[k] = '0;
			m_tag[k] = '0;
		end
		for (k = 0; k < num_rows; k++)
			row_err[k] = 0;

		// grp, mode, opcode, dest or nzp, predict, value, addr, expected, busy, redirect
		add_row(0, 0, lc3b_commit_pkg::op_add, 1, 0, 16'h0005, 16'h0, 16'h0005, 0, 0);
		add_row(0, 0, lc3b_commit_pkg::op_and, 2, 0, 16'h0000, 16'h0, 16'h0000, 0, 0);
		add_row(0, 0, lc3b_commit_pkg::op_not, 3, 0, 16'hfffa, 16'h0, 16'hfffa, 0, 0);
		add_row(1, 0, lc3b_commit_pkg::op_br, 3'b100, 1, 16'h3000, 16'h0, 16'h0, 0, 0);
		add_row(2, 0, lc3b_commit_pkg::op_add, 4, 0, 16'h0011, 16'h0, 16'h0011, 1, 0);
		add_row(2, 1, lc3b_commit_pkg::op_lea, 4, 0, 16'h1234, 16'h0, 16'h1234, 0, 0);
		add_row(3, 0, lc3b_commit_pkg::op_str, 0, 0, 16'hbeef, 16'h4000, 16'hbeef, 0, 0);
		add_row(3, 0, lc3b_commit_pkg::op_add, 5, 0, 16'h0022, 16'h0, 16'h0022, 0, 0);
		add_row(3, 0, lc3b_commit_pkg::op_stb, 0, 0, 16'h12ab, 16'h4003, 16'habab, 0, 0);
		add_row(3, 0, lc3b_commit_pkg::op_jsr, 6, 0, 16'h0400, 16'h0, 16'h0400, 0, 0);
		add_row(4, 0, lc3b_commit_pkg::op_add, 1, 0, 16'h8000, 16'h0, 16'h8000, 0, 0);
		add_row(4, 0, lc3b_commit_pkg::op_br, 3'b001, 1, 16'h3100, 16'h0, 16'h0, 0, 1);
		add_row(4, 2, lc3b_commit_pkg::op_add, 2, 0, 16'h0bad, 16'h0, 16'h0000, 0, 0);
		add_row(5, 0, lc3b_commit_pkg::op_trap, 0, 0, 16'h0025, 16'h0, 16'h0025, 0, 1);
		add_row(5, 2, lc3b_commit_pkg::op_add, 3, 0, 16'h0bad, 16'h0, 16'hfffa, 0, 0);
		add_row(6, 0, lc3b_commit_pkg::op_br, 3'b010, 0, 16'h3200, 16'h0, 16'h0, 0, 0);
		add_row(6, 0, lc3b_commit_pkg::op_ldb, 0, 0, 16'h00ff, 16'h0, 16'h00ff, 0, 0);

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		i = 0;
		carry = -1;
		checked = 0;
		while (i < num_rows) begin
			first = i;
			while (i < num_rows && rows[i].grp == rows[first].grp) begin
				dispatch(i);
				i++;
			end
			for (k = i - 1; k >= first; k--) begin
				if (rows[k].mode != 1)
					complete(k); // Youngest first, so completions arrive out of order
			end
			if (carry >= 0)
				complete(carry);
			carry = (rows[i-1].mode == 1) ? i - 1 : -1;
			last = -1;
			for (k = first; k < i; k++) begin
				if (rows[k].mode == 0)
					last = k;
			end
			if (last >= 0) begin
				while (!retired[last])
					step();
			end
			for (k = checked; k < i; k++) begin
				if (k != carry)
					check_row(k);
			end
			checked = (carry >= 0) ? carry : i;
		end

		// Final sweep against the reference model
		for (k = 0; k < 8; k++) begin
			read_reg(k, v, b, t);
			if (v !== m_regs[k] || b !== m_busy[k] || (m_busy[k] && t !== m_tag[k])) begin
				$display("Error: R%0d rd_value 0x%h rd_busy 0x%h rd_tag 0x%h, %s 0x%h 0x%h 0x%h",
					k, v, b, t, "model expects", m_regs[k], m_busy[k], m_tag[k]);
				note_error(-1);
			end
		end
		if (bus_count != stores_retired) begin
			$display("Error: store cycles 0x%h, expected 0x%h", bus_count, stores_retired);
			note_error(-1);
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d", passed + failed,
			passed, failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: vlog.f
hw/lc3b_commit_pkg.sv
hw/reorder_buffer.sv
hw/commit_control.sv
hw/branch_resolve.sv
hw/arch_regfile.sv
hw/store_commit_port.sv
hw/commit_unit_top.sv
sim/clock_gen.sv
sim/commit_unit_tb.sv
